// File: verilog/FetchPkg.sv
package FetchPkg;

    localparam int NumSlots = 4;
    localparam int FetchIdBits = 5;
    localparam int BtbEntries = 16;
    localparam int CacheSets = 32;
    localparam int LineWords = 4;
    localparam int HistBits = 8;

    // Derived address fields, all in halfword PC bits.
    localparam int PcBits = 31;
    localparam int SlotBits = $clog2(NumSlots);
    localparam int LineOffsetBits = $clog2(LineWords * NumSlots);
    localparam int CacheSetBits = $clog2(CacheSets);
    localparam int CacheTagBits = PcBits - LineOffsetBits - CacheSetBits;
    localparam int BtbIdxBits = $clog2(BtbEntries);
    localparam int BtbTagBits = PcBits - SlotBits - BtbIdxBits;
    localparam int FetchAddrBits = PcBits - SlotBits;
    localparam int LineAddrBits = 26;
    localparam int McProgressBits = 10;

    typedef logic [FetchIdBits-1:0] FetchId_t;
    typedef logic [PcBits-1:0] Pc_t;
    typedef logic [HistBits-1:0] BHist_t;

    typedef struct packed {
        logic taken;
        logic isJump;
    } BranchPredInfo;

    typedef struct packed {
        logic found;
        logic isJump;
        Pc_t src;
        Pc_t dst;
    } BranchPrediction;

    typedef struct packed {
        logic valid;
        logic isJump;
        Pc_t src;
        Pc_t dst;
    } BranchUpdate;

    typedef struct packed {
        logic valid;
        Pc_t pc;
        FetchId_t fetchId;
    } Redirect;

    typedef struct packed {
        Pc_t pc;
        BHist_t hist;
        BranchPredInfo bpi;
        logic [SlotBits-1:0] branchPos;
    } PCFileEntry;

    typedef struct packed {
        logic [15:0] instr;
        Pc_t pc;
        FetchId_t fetchId;
        logic valid;
        logic predTaken;
    } IfInstr;

    // Line address counts 32-byte lines.
    typedef struct packed {
        logic valid;
        logic [LineAddrBits-1:0] lineAddr;
        logic cacheId;
    } McRequest;

    typedef enum logic [1:0] {
        Idle,
        Request,
        Filling,
        Install
    } CacheState_t;

endpackage

// File: verilog/PCFile.sv
`timescale 1ns/1ps

module PCFile (
    input logic clk,
    input logic wen,
    input FetchPkg::FetchId_t waddr,
    input FetchPkg::PCFileEntry wdata,
    input FetchPkg::FetchId_t raddr0,
    input FetchPkg::FetchId_t raddr1,
    output FetchPkg::PCFileEntry rdata0,
    output FetchPkg::PCFileEntry rdata1
);

    // One entry per fetch ID in the ring.
    FetchPkg::PCFileEntry entries [2**FetchPkg::FetchIdBits];

    always_ff @(posedge clk) begin
        if (wen) begin
            entries[waddr] <= wdata;
        end
    end

    assign rdata0 = entries[raddr0];
    assign rdata1 = entries[raddr1];

endmodule

// File: verilog/BranchTargetBuffer.sv
`timescale 1ns/1ps

module BranchTargetBuffer (
    input logic clk,
    input logic rst,
    input FetchPkg::Pc_t lookupPc,
    input FetchPkg::BranchUpdate update,
    output FetchPkg::BranchPrediction prediction,
    output FetchPkg::BHist_t history,
    output FetchPkg::BranchPredInfo info,
    input logic lookupEn
);

    logic [FetchPkg::BtbEntries-1:0] entryValid;
    logic [FetchPkg::BtbTagBits-1:0] entryTag [FetchPkg::BtbEntries];
    logic [FetchPkg::SlotBits-1:0] entryPos [FetchPkg::BtbEntries];
    logic entryJump [FetchPkg::BtbEntries];
    FetchPkg::Pc_t entryDst [FetchPkg::BtbEntries];

    logic [FetchPkg::BtbIdxBits-1:0] lookupIdx;
    logic [FetchPkg::BtbIdxBits-1:0] updateIdx;
    logic hit;

    assign lookupIdx = lookupPc[FetchPkg::SlotBits +: FetchPkg::BtbIdxBits];
    assign updateIdx = update.src[FetchPkg::SlotBits +: FetchPkg::BtbIdxBits];

    // Branches before the entry slot are skipped.
    assign hit = entryValid[lookupIdx]
        && entryTag[lookupIdx] == lookupPc[FetchPkg::PcBits-1 -: FetchPkg::BtbTagBits]
        && entryPos[lookupIdx] >= lookupPc[FetchPkg::SlotBits-1:0];

    always_comb begin
        prediction.found = hit;
        prediction.isJump = hit && entryJump[lookupIdx];
        prediction.src = {lookupPc[FetchPkg::PcBits-1:FetchPkg::SlotBits], entryPos[lookupIdx]};
        prediction.dst = entryDst[lookupIdx];
        // Every hit predicts taken.
        info.taken = hit;
        info.isJump = hit && entryJump[lookupIdx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            history <= '0;
        end else begin
            if (update.valid) begin
                entryValid[updateIdx] <= 1'b1;
            end
            if (lookupEn) begin
                history <= {history[FetchPkg::HistBits-2:0], info.taken};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            entryTag[updateIdx] <= update.src[FetchPkg::PcBits-1 -: FetchPkg::BtbTagBits];
            entryPos[updateIdx] <= update.src[FetchPkg::SlotBits-1:0];
            entryJump[updateIdx] <= update.isJump;
            entryDst[updateIdx] <= update.dst;
        end
    end

    assert property (@(posedge clk) disable iff (rst) update.valid |-> !$isunknown(update.src));

endmodule

// File: verilog/ICacheTable.sv
`timescale 1ns/1ps

module ICacheTable (
    input logic clk,
    input logic rst,
    input logic lookupValid,
    input FetchPkg::Pc_t lookupPc,
    output logic [FetchPkg::FetchAddrBits-1:0] lookupAddress,
    output logic stall,
    output FetchPkg::McRequest mcReq,
    input logic mcBusy,
    input logic [FetchPkg::McProgressBits-1:0] mcProgress
);

    FetchPkg::CacheState_t state;
    logic [FetchPkg::CacheSets-1:0] tagValid;
    logic [FetchPkg::CacheTagBits-1:0] tags [FetchPkg::CacheSets];

    logic [FetchPkg::CacheSetBits-1:0] lookupSet;
    logic [FetchPkg::CacheSetBits-1:0] missSet;
    logic [FetchPkg::CacheTagBits-1:0] lookupTag;
    logic [FetchPkg::FetchAddrBits-1:0] lastAddress;
    FetchPkg::Pc_t missPc;
    logic hit;
    logic sawBusy;
    logic lineDone;

    assign lookupSet = lookupPc[FetchPkg::LineOffsetBits +: FetchPkg::CacheSetBits];
    assign lookupTag = lookupPc[FetchPkg::PcBits-1 -: FetchPkg::CacheTagBits];
    assign missSet = missPc[FetchPkg::LineOffsetBits +: FetchPkg::CacheSetBits];
    assign hit = tagValid[lookupSet] && tags[lookupSet] == lookupTag;

    // Memory keeps seeing the last looked-up block until the next lookup.
    assign lookupAddress = lookupValid ? lookupPc[FetchPkg::PcBits-1:FetchPkg::SlotBits]
                                       : lastAddress;
    assign stall = state != FetchPkg::Idle;

    assign mcReq.valid = state == FetchPkg::Request && !mcBusy;
    assign mcReq.lineAddr = missPc[FetchPkg::LineOffsetBits +: FetchPkg::LineAddrBits];
    assign mcReq.cacheId = 1'b0;

    always_ff @(posedge clk) begin
        if (lookupValid) begin
            lastAddress <= lookupPc[FetchPkg::PcBits-1:FetchPkg::SlotBits];
        end
        if (state == FetchPkg::Idle && lookupValid && !hit) begin
            missPc <= lookupPc;
        end
        if (state == FetchPkg::Install) begin
            tags[missSet] <= missPc[FetchPkg::PcBits-1 -: FetchPkg::CacheTagBits];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FetchPkg::Idle;
            tagValid <= '0;
            sawBusy <= 1'b0;
            lineDone <= 1'b0;
        end else begin
            case (state)
                FetchPkg::Idle: begin
                    if (lookupValid && !hit) begin
                        state <= FetchPkg::Request;
                    end
                end
                FetchPkg::Request: begin
                    sawBusy <= 1'b0;
                    lineDone <= 1'b0;
                    if (!mcBusy) begin
                        state <= FetchPkg::Filling;
                    end
                end
                FetchPkg::Filling: begin
                    // Fill ends when busy falls after all beats arrived.
                    if (mcBusy) begin
                        sawBusy <= 1'b1;
                    end
                    if (mcProgress >= FetchPkg::McProgressBits'(FetchPkg::LineWords)) begin
                        lineDone <= 1'b1;
                    end
                    if (sawBusy && !mcBusy && lineDone) begin
                        state <= FetchPkg::Install;
                    end
                end
                FetchPkg::Install: begin
                    tagValid[missSet] <= 1'b1;
                    state <= FetchPkg::Idle;
                end
                default: state <= FetchPkg::Idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) mcReq.valid |=> !mcReq.valid);
    assert property (@(posedge clk) disable iff (rst) mcBusy |-> !mcReq.valid);

endmodule

// File: verilog/ProgramCounter.sv
`timescale 1ns/1ps

module ProgramCounter (
    input logic clk,
    input logic rst,
    input FetchPkg::Redirect redirect,
    input FetchPkg::FetchId_t robFetchId,
    input logic [63:0] instrData,
    input FetchPkg::BranchPrediction prediction,
    input FetchPkg::BHist_t history,
    input FetchPkg::BranchPredInfo info,
    input logic cacheStall,
    output logic lookupEn,
    output FetchPkg::Pc_t pc,
    output logic pcFileWen,
    output FetchPkg::FetchId_t pcFileWaddr,
    output FetchPkg::PCFileEntry pcFileWdata,
    output FetchPkg::IfInstr instrs [FetchPkg::NumSlots],
    output logic stall
);

    FetchPkg::FetchId_t fetchId;
    FetchPkg::Pc_t nextPc;
    logic stageValid;
    logic advance;

    // Stage 0 state.
    FetchPkg::Pc_t pcLast;
    FetchPkg::BHist_t histLast;
    FetchPkg::BranchPredInfo infoLast;
    logic [FetchPkg::SlotBits-1:0] branchPosLast;

    // Stage 1 output block.
    logic [FetchPkg::NumSlots-1:0] slotValid;
    logic [FetchPkg::NumSlots-1:0] slotTaken;
    logic [63:0] slotData;
    FetchPkg::Pc_t blockPc;
    FetchPkg::FetchId_t blockId;

    // Ring full when the next ID reaches the oldest one in the ROB.
    assign stall = robFetchId == fetchId || cacheStall;
    assign lookupEn = !stall && !redirect.valid;
    assign advance = stageValid && !stall && !redirect.valid;

    assign nextPc = prediction.found
        ? prediction.dst
        : {pc[FetchPkg::PcBits-1:FetchPkg::SlotBits] + 1'b1, {FetchPkg::SlotBits{1'b0}}};

    assign pcFileWen = advance;
    assign pcFileWaddr = fetchId;

    always_comb begin
        pcFileWdata.pc = pcLast;
        pcFileWdata.hist = histLast;
        pcFileWdata.bpi = infoLast;
        pcFileWdata.branchPos = branchPosLast;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fetchId <= '0;
            stageValid <= 1'b0;
            slotValid <= '0;
            slotTaken <= '0;
        end else if (redirect.valid) begin
            pc <= redirect.pc;
            fetchId <= redirect.fetchId + 1'b1;
            stageValid <= 1'b0;
            slotValid <= '0;
            slotTaken <= '0;
        end else begin
            if (lookupEn) begin
                pc <= nextPc;
                stageValid <= 1'b1;
            end
            if (advance) begin
                fetchId <= fetchId + 1'b1;
            end
            for (int i = 0; i < FetchPkg::NumSlots; i++) begin
                slotValid[i] <= advance
                    && i >= pcLast[FetchPkg::SlotBits-1:0]
                    && (!infoLast.taken || i <= branchPosLast);
                slotTaken[i] <= advance && infoLast.taken && i == branchPosLast;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookupEn) begin
            pcLast <= pc;
            histLast <= history;
            infoLast <= info;
            branchPosLast <= prediction.src[FetchPkg::SlotBits-1:0];
        end
        if (advance) begin
            slotData <= instrData;
            blockPc <= pcLast;
            blockId <= fetchId;
        end
    end

    always_comb begin
        for (int i = 0; i < FetchPkg::NumSlots; i++) begin
            instrs[i].instr = slotData[16*i +: 16];
            instrs[i].pc = {blockPc[FetchPkg::PcBits-1:FetchPkg::SlotBits],
                            FetchPkg::SlotBits'(i)};
            instrs[i].fetchId = blockId;
            instrs[i].valid = slotValid[i];
            instrs[i].predTaken = slotTaken[i];
        end
    end

    assert property (@(posedge clk) disable iff (rst) redirect.valid |-> !lookupEn);

endmodule

// File: verilog/FetchUnit.sv
`timescale 1ns/1ps

module FetchUnit (
    input logic clk,
    input logic rst,
    input FetchPkg::Redirect redirect,
    input FetchPkg::BranchUpdate branchUpdate,
    input FetchPkg::FetchId_t robFetchId,
    input FetchPkg::FetchId_t pcReadAddr0,
    input FetchPkg::FetchId_t pcReadAddr1,
    output FetchPkg::PCFileEntry pcReadData0,
    output FetchPkg::PCFileEntry pcReadData1,
    output logic [28:0] instrAddr,
    input logic [63:0] instrData,
    output FetchPkg::IfInstr instrs [FetchPkg::NumSlots],
    output logic stall,
    output FetchPkg::McRequest mcReq,
    input logic mcBusy,
    input logic [9:0] mcProgress
);

    logic lookupEn;
    logic cacheStall;
    logic pcFileWen;
    FetchPkg::Pc_t pc;
    FetchPkg::FetchId_t pcFileWaddr;
    FetchPkg::PCFileEntry pcFileWdata;
    FetchPkg::BranchPrediction prediction;
    FetchPkg::BHist_t history;
    FetchPkg::BranchPredInfo info;

    ProgramCounter i_ProgramCounter (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .robFetchId(robFetchId),
        .instrData(instrData),
        .prediction(prediction),
        .history(history),
        .info(info),
        .cacheStall(cacheStall),
        .lookupEn(lookupEn),
        .pc(pc),
        .pcFileWen(pcFileWen),
        .pcFileWaddr(pcFileWaddr),
        .pcFileWdata(pcFileWdata),
        .instrs(instrs),
        .stall(stall)
    );

    BranchTargetBuffer i_BranchTargetBuffer (
        .clk(clk),
        .rst(rst),
        .lookupPc(pc),
        .update(branchUpdate),
        .prediction(prediction),
        .history(history),
        .info(info),
        .lookupEn(lookupEn)
    );

    ICacheTable i_ICacheTable (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupEn),
        .lookupPc(pc),
        .lookupAddress(instrAddr),
        .stall(cacheStall),
        .mcReq(mcReq),
        .mcBusy(mcBusy),
        .mcProgress(mcProgress)
    );

    PCFile i_PCFile (
        .clk(clk),
        .wen(pcFileWen),
        .waddr(pcFileWaddr),
        .wdata(pcFileWdata),
        .raddr0(pcReadAddr0),
        .raddr1(pcReadAddr1),
        .rdata0(pcReadData0),
        .rdata1(pcReadData1)
    );

endmodule

// File: tests/FetchUnit_tb.sv
`timescale 1ns/1ps

module FetchUnit_tb;

    localparam int ClkPeriod = 4;
    localparam int ResetCycles = 16;
    localparam int NumRows = 5;

    typedef struct packed {
        FetchPkg::Pc_t redirPc;
        FetchPkg::FetchId_t fid;
        FetchPkg::BranchUpdate upd;
        logic robHold;
        logic [2:0] nBlocks;
        logic [1:0] expReqs;
        logic [25:0] expLine;
        FetchPkg::Pc_t [3:0] expPc;
    } RowSpec;

    logic clk;
    logic rst;
    FetchPkg::Redirect redirect;
    FetchPkg::BranchUpdate branchUpdate;
    FetchPkg::FetchId_t robFetchId;
    FetchPkg::FetchId_t pcReadAddr0;
    FetchPkg::FetchId_t pcReadAddr1;
    FetchPkg::PCFileEntry pcReadData0;
    FetchPkg::PCFileEntry pcReadData1;
    logic [28:0] instrAddr;
    logic [63:0] instrData;
    FetchPkg::IfInstr instrs [FetchPkg::NumSlots];
    logic stall;
    FetchPkg::McRequest mcReq;
    logic mcBusy;
    logic [9:0] mcProgress;

    RowSpec rows [NumRows];
    int errors = 0;
    int reqCount = 0;
    logic [25:0] reqLine;
    logic sawStall = 1'b0;
    logic collecting = 1'b0;
    integer seed = 32'h535ffdbc;

    // Collected output blocks.
    FetchPkg::Pc_t bBase [$];
    FetchPkg::FetchId_t bId [$];
    logic [3:0] bValid [$];
    logic [3:0] bTaken [$];
    logic [63:0] bData [$];

    // Reference branch buffer contents.
    logic btbValid [16];
    FetchPkg::Pc_t btbSrc [16];

    FetchUnit i_FetchUnit (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .branchUpdate(branchUpdate),
        .robFetchId(robFetchId),
        .pcReadAddr0(pcReadAddr0),
        .pcReadAddr1(pcReadAddr1),
        .pcReadData0(pcReadData0),
        .pcReadData1(pcReadData1),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .instrs(instrs),
        .stall(stall),
        .mcReq(mcReq),
        .mcBusy(mcBusy),
        .mcProgress(mcProgress)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [63:0] memWord(input logic [28:0] addr);
        return {addr ^ 29'h15a5a5a5, 3'b101, ~addr, 3'b011};
    endfunction

    // Slot flags from the entry PC and any taken branch in the block.
    task automatic expectedSlots(input FetchPkg::Pc_t pc, output logic [3:0] v,
                                 output logic [3:0] t, output logic taken,
                                 output logic [1:0] pos);
        int idx;
        idx = pc[5:2];
        taken = btbValid[idx] && btbSrc[idx][30:2] == pc[30:2]
            && btbSrc[idx][1:0] >= pc[1:0];
        pos = btbSrc[idx][1:0];
        for (int i = 0; i < 4; i++) begin
            v[i] = i >= pc[1:0] && (!taken || i <= pos);
            t[i] = taken && i == pos;
        end
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        instrData <= memWord(instrAddr);
    end

    always @(negedge clk) begin
        logic [3:0] v;
        logic [3:0] t;
        if (mcReq.valid) begin
            reqCount++;
            reqLine = mcReq.lineAddr;
        end
        if (stall) begin
            sawStall = 1'b1;
        end
        for (int i = 0; i < 4; i++) begin
            v[i] = instrs[i].valid;
            t[i] = instrs[i].predTaken;
        end
        if (collecting && v != 4'b0000) begin
            if (mcBusy) begin
                errors++;
                $display("A valid bundle appeared while a line fill was running.");
            end
            bBase.push_back(instrs[0].pc);
            bId.push_back(instrs[0].fetchId);
            bValid.push_back(v);
            bTaken.push_back(t);
            bData.push_back({instrs[3].instr, instrs[2].instr,
                             instrs[1].instr, instrs[0].instr});
        end
    end

    // Memory controller answers each request with a busy window of 4 to 8 cycles.
    initial begin
        int n;
        forever begin
            @(negedge clk);
            if (mcReq.valid) begin
                n = 4 + ($unsigned($random(seed)) % 5);
                @(posedge clk);
                mcBusy <= 1'b1;
                mcProgress <= '0;
                repeat (n) begin
                    @(posedge clk);
                    mcProgress <= mcProgress + 1'b1;
                end
                mcBusy <= 1'b0;
            end
        end
    end

    initial begin
        #(ClkPeriod * (ResetCycles + NumRows * 64));
        $display("Timeout: the fetch sequence did not finish in time.");
        $display("Regression failed");
        $finish;
    end

    task automatic applyRow(input RowSpec row);
        logic [3:0] v;
        logic [3:0] t;
        logic taken;
        logic [1:0] pos;
        FetchPkg::FetchId_t id;
        int idx;
        if (row.upd.valid) begin
            @(posedge clk);
            branchUpdate <= row.upd;
            @(posedge clk);
            branchUpdate <= '0;
            idx = row.upd.src[5:2];
            btbValid[idx] = 1'b1;
            btbSrc[idx] = row.upd.src;
        end
        @(posedge clk);
        collecting = 1'b0;
        redirect <= '{valid: 1'b1, pc: row.redirPc, fetchId: row.fid};
        // ROB limit stops fetch right after the expected blocks.
        robFetchId <= FetchPkg::FetchId_t'(row.fid + 1 + (row.robHold ? 2 : row.nBlocks));
        @(posedge clk);
        redirect <= '0;
        bBase.delete();
        bId.delete();
        bValid.delete();
        bTaken.delete();
        bData.delete();
        reqCount = 0;
        sawStall = 1'b0;
        collecting = 1'b1;
        if (row.robHold) begin
            while (bBase.size() < 2) @(negedge clk);
            repeat (10) @(negedge clk);
            checkValue("stall", stall, 1);
            checkValue("bundle count", bBase.size(), 2);
            @(posedge clk);
            robFetchId <= FetchPkg::FetchId_t'(row.fid + 1 + row.nBlocks);
        end
        while (bBase.size() < row.nBlocks) @(negedge clk);
        repeat (4) @(posedge clk);
        checkValue("bundle count", bBase.size(), row.nBlocks);
        checkValue("mcReq count", reqCount, row.expReqs);
        if (row.expReqs != 0) begin
            checkValue("mcReq.lineAddr", reqLine, row.expLine);
            checkValue("stall", sawStall, 1);
        end
        for (int j = 0; j < row.nBlocks && j < bBase.size(); j++) begin
            expectedSlots(row.expPc[j], v, t, taken, pos);
            id = FetchPkg::FetchId_t'(row.fid + 1 + j);
            checkValue("instrs.pc", bBase[j], {row.expPc[j][30:2], 2'b00});
            checkValue("instrs.fetchId", bId[j], id);
            checkValue("instrs.valid", bValid[j], v);
            checkValue("instrs.predTaken", bTaken[j], t);
            checkValue("instrs.instr", bData[j], memWord(row.expPc[j][30:2]));
            @(posedge clk);
            pcReadAddr0 <= id;
            pcReadAddr1 <= id;
            @(negedge clk);
            checkValue("pcReadData0.pc", pcReadData0.pc, row.expPc[j]);
            checkValue("pcReadData1.bpi.taken", pcReadData1.bpi.taken, taken);
            if (taken) begin
                checkValue("pcReadData1.branchPos", pcReadData1.branchPos, pos);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        redirect = '0;
        branchUpdate = '0;
        robFetchId = '0;
        pcReadAddr0 = '0;
        pcReadAddr1 = '0;
        instrData = '0;
        mcBusy = 1'b0;
        mcProgress = '0;
        for (int i = 0; i < 16; i++) begin
            btbValid[i] = 1'b0;
        end

        // Halfword PCs; a cache line is 16 halfwords.
        rows[0] = '{redirPc: 31'h100, fid: 5'd3, upd: '0, robHold: 1'b0, nBlocks: 3'd3,
                    expReqs: 2'd1, expLine: 26'h10,
                    expPc: {31'h0, 31'h108, 31'h104, 31'h100}};
        rows[1] = '{redirPc: 31'h102, fid: 5'd10, upd: '0, robHold: 1'b0, nBlocks: 3'd3,
                    expReqs: 2'd0, expLine: 26'h0,
                    expPc: {31'h0, 31'h108, 31'h104, 31'h102}};
        rows[2] = '{redirPc: 31'h100, fid: 5'd20,
                    upd: '{valid: 1'b1, isJump: 1'b0, src: 31'h105, dst: 31'h201},
                    robHold: 1'b0, nBlocks: 3'd4, expReqs: 2'd1, expLine: 26'h20,
                    expPc: {31'h204, 31'h201, 31'h104, 31'h100}};
        rows[3] = '{redirPc: 31'h200, fid: 5'd28, upd: '0, robHold: 1'b1, nBlocks: 3'd3,
                    expReqs: 2'd0, expLine: 26'h0,
                    expPc: {31'h0, 31'h208, 31'h204, 31'h200}};
        rows[4] = '{redirPc: 31'h301, fid: 5'd5, upd: '0, robHold: 1'b0, nBlocks: 3'd3,
                    expReqs: 2'd1, expLine: 26'h30,
                    expPc: {31'h0, 31'h308, 31'h304, 31'h301}};

        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("stall", stall, 1);
        checkValue("mcReq.valid", mcReq.valid, 0);
        checkValue("instrs.valid", {instrs[3].valid, instrs[2].valid,
                                    instrs[1].valid, instrs[0].valid}, 0);

        for (int r = 0; r < NumRows; r++) begin
            applyRow(rows[r]);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/FetchPkg.sv
verilog/PCFile.sv
verilog/BranchTargetBuffer.sv
verilog/ICacheTable.sv
verilog/ProgramCounter.sv
verilog/FetchUnit.sv
tests/FetchUnit_tb.sv

// File: Bender.yml
package:
  name: fetch_unit

sources:
  - verilog/FetchPkg.sv
  - verilog/PCFile.sv
  - verilog/BranchTargetBuffer.sv
  - verilog/ICacheTable.sv
  - verilog/ProgramCounter.sv
  - verilog/FetchUnit.sv
  - target: test
    files:
      - tests/FetchUnit_tb.sv
